// ==== logic/lc3b_isa_pkg.sv ====
`default_nettype none

package lc3b_isa_pkg;

	localparam int word_width = 16;
	localparam int reg_count = 8;

	// Instruction field positions
	localparam int opcode_msb = 15;
	localparam int opcode_lsb = 12;
	localparam int dr_msb = 11;		// Also the STR source register
	localparam int dr_lsb = 9;
	localparam int sr1_msb = 8;
	localparam int sr1_lsb = 6;
	localparam int sr2_msb = 2;
	localparam int sr2_lsb = 0;
	localparam int imm_sel_bit = 5;		// ALU immediate form when set

	// Immediates sit in the low bits
	localparam int imm5_width = 5;
	localparam int off6_width = 6;

	// Only the issued subset, at LC-3b encodings
	typedef enum logic [3:0]
	{
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} opcode_e;

	typedef logic [$clog2(reg_count)-1:0] reg_idx_t;
	typedef logic [word_width-1:0] word_t;

endpackage

`default_nettype wire

// ==== logic/tomasulo_pkg.sv ====
`default_nettype none

package tomasulo_pkg;

	import lc3b_isa_pkg::*;

	localparam int tag_width = 3;
	localparam int alu_station_count = 3;
	localparam int station_id_width = 2;

	typedef logic [tag_width-1:0] rob_tag_t;
	typedef logic [station_id_width-1:0] station_id_t;

	// Common data bus broadcast
	typedef struct packed
	{
		logic valid;
		rob_tag_t tag;
		word_t data;
	} cdb_t;

	// One register file read port
	typedef struct packed
	{
		logic busy;
		word_t data;
		rob_tag_t rob_entry;	// Producer when busy
	} reg_read_t;

	typedef struct packed
	{
		logic valid;
		word_t data;
	} rob_read_t;

	// Value when ready, producer tag otherwise
	typedef struct packed
	{
		logic ready;
		word_t value;
		rob_tag_t tag;
	} operand_t;

	typedef struct packed
	{
		logic valid;
		opcode_e opcode;
		reg_idx_t dest;
		reg_idx_t sr1;
		reg_idx_t src2;		// sr2, or the store source
		logic imm_sel;
		word_t imm;
	} decoded_t;

	typedef struct packed
	{
		logic write;
		station_id_t station;
		opcode_e opcode;
		operand_t j;
		operand_t k;
		rob_tag_t dest;
	} rs_write_t;

	typedef struct packed
	{
		logic write;
		opcode_e opcode;
		operand_t base;
		operand_t src;
		word_t offset;
		rob_tag_t dest;
	} ldst_write_t;

	typedef struct packed
	{
		logic write;
		opcode_e opcode;
		reg_idx_t dest;
	} rob_write_t;

	typedef struct packed
	{
		logic write;
		reg_idx_t dest;
		rob_tag_t tag;
	} reg_busy_t;

endpackage

`default_nettype wire

// ==== logic/issue_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_decode
	import lc3b_isa_pkg::*, tomasulo_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic flush,
	// Fetch side
	input wire logic instr_valid,
	input word_t instr,
	output logic instr_ready,
	// From the router
	input wire logic issue_fire,
	output decoded_t decoded,
	// Register file read indices
	output reg_idx_t sr1_idx,
	output reg_idx_t src2_idx
);

	word_t instr_q;
	logic valid_q;
	opcode_e opcode;
	logic is_mem;
	word_t imm5_sext;
	word_t off6_adj;
	logic accept;

	// Empty, or freed by this cycle's issue
	assign instr_ready = ~valid_q | issue_fire;
	assign accept = instr_valid & instr_ready;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			valid_q <= 1'b0;
		else if (flush)
			valid_q <= 1'b0;	// Drop without issuing
		else if (instr_ready)
			valid_q <= instr_valid;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			instr_q <= instr;
	end

	assign opcode = opcode_e'(instr_q[opcode_msb:opcode_lsb]);
	assign is_mem = (opcode == op_ldr) || (opcode == op_str);

	assign imm5_sext = {{(word_width-imm5_width){instr_q[imm5_width-1]}},
		instr_q[imm5_width-1:0]};

	// Word offset, so shifted left one
	assign off6_adj = {{(word_width-off6_width-1){instr_q[off6_width-1]}},
		instr_q[off6_width-1:0], 1'b0};

	always_comb
	begin
		decoded.valid = valid_q;
		decoded.opcode = opcode;
		decoded.dest = instr_q[dr_msb:dr_lsb];
		decoded.sr1 = instr_q[sr1_msb:sr1_lsb];

		// STR reads its source through the second port
		if (opcode == op_str)
			decoded.src2 = instr_q[dr_msb:dr_lsb];
		else
			decoded.src2 = instr_q[sr2_msb:sr2_lsb];

		decoded.imm_sel = is_mem | instr_q[imm_sel_bit];
		decoded.imm = is_mem ? off6_adj : imm5_sext;
	end

	assign sr1_idx = decoded.sr1;
	assign src2_idx = decoded.src2;

endmodule

`default_nettype wire

// ==== logic/operand_resolve.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_resolve
	import tomasulo_pkg::*;
(
	input reg_read_t reg_in,
	input rob_read_t rob_in,
	input cdb_t cdb,
	output operand_t operand
);

	logic cdb_hit;

	// Producer is broadcasting right now
	assign cdb_hit = cdb.valid && (cdb.tag == reg_in.rob_entry);

	always_comb
	begin
		operand.ready = 1'b1;
		operand.value = reg_in.data;
		operand.tag = reg_in.rob_entry;

		if (reg_in.busy)
		begin
			if (cdb_hit)
			begin
				operand.value = cdb.data;
			end
			else if (rob_in.valid)
			begin
				// Done but not yet committed
				operand.value = rob_in.data;
			end
			else
			begin
				// Station waits on the producer tag
				operand.ready = 1'b0;
				operand.value = '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/dispatch_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module dispatch_router
	import lc3b_isa_pkg::*, tomasulo_pkg::*;
(
	input decoded_t decoded,
	input operand_t op_j,
	input operand_t op_k,
	input operand_t op_src,
	// Back-end status
	input wire logic [alu_station_count-1:0] alu_busy,
	input wire logic ldst_full,
	input wire logic rob_full,
	input rob_tag_t rob_tail,
	// Writes, one-cycle pulses
	output rs_write_t rs_write,
	output ldst_write_t ldst_write,
	output rob_write_t rob_write,
	output reg_busy_t reg_busy,
	output logic issue_fire
);

	logic is_alu;
	logic is_load;
	logic is_store;
	logic is_mem;
	logic stall;
	station_id_t free_station;
	operand_t imm_operand;

	assign is_alu = (decoded.opcode == op_add) || (decoded.opcode == op_and)
		|| (decoded.opcode == op_not);
	assign is_load = (decoded.opcode == op_ldr);
	assign is_store = (decoded.opcode == op_str);
	assign is_mem = is_load | is_store;

	assign stall = rob_full
		|| (is_alu && (&alu_busy))
		|| (is_mem && ldst_full);

	// Unsupported opcodes leave without any write
	assign issue_fire = decoded.valid & ~stall;

	// Lowest-numbered free station wins
	always_comb
	begin
		free_station = '0;
		for (int i = alu_station_count - 1; i >= 0; i--)
		begin
			if (!alu_busy[i])
				free_station = station_id_t'(i);
		end
	end

	assign imm_operand = '{ready: 1'b1, value: decoded.imm, tag: '0};

	always_comb
	begin
		rs_write.write = issue_fire & is_alu;
		rs_write.station = free_station;
		rs_write.opcode = decoded.opcode;
		rs_write.j = op_j;
		rs_write.k = decoded.imm_sel ? imm_operand : op_k;
		rs_write.dest = rob_tail;
	end

	always_comb
	begin
		ldst_write.write = issue_fire & is_mem;
		ldst_write.opcode = decoded.opcode;
		ldst_write.base = op_j;
		ldst_write.offset = decoded.imm;
		ldst_write.dest = rob_tail;

		// Loads have nothing to wait on here
		if (is_store)
			ldst_write.src = op_src;
		else
			ldst_write.src = '{ready: 1'b1, value: '0, tag: '0};
	end

	always_comb
	begin
		rob_write.write = issue_fire & (is_alu | is_mem);
		rob_write.opcode = decoded.opcode;
		rob_write.dest = is_store ? reg_idx_t'(0) : decoded.dest;	// Stores write no register
	end

	// Rename the destination to the new ROB entry
	always_comb
	begin
		reg_busy.write = issue_fire & (is_alu | is_load);
		reg_busy.dest = decoded.dest;
		reg_busy.tag = rob_tail;
	end

endmodule

`default_nettype wire

// ==== logic/issue_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_unit
	import lc3b_isa_pkg::*, tomasulo_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic flush,
	// Fetch
	input wire logic instr_valid,
	input word_t instr,
	output logic instr_ready,
	// Register file
	output reg_idx_t sr1_idx,
	output reg_idx_t src2_idx,
	input reg_read_t reg_a,
	input reg_read_t reg_b,
	// ROB reads
	output rob_tag_t rob_tag_a,
	output rob_tag_t rob_tag_b,
	input rob_read_t rob_a,
	input rob_read_t rob_b,
	input cdb_t cdb,
	// Back-end status
	input wire logic [alu_station_count-1:0] alu_busy,
	input wire logic ldst_full,
	input wire logic rob_full,
	input rob_tag_t rob_tail,
	// Dispatch writes
	output rs_write_t rs_write,
	output ldst_write_t ldst_write,
	output rob_write_t rob_write,
	output reg_busy_t reg_busy
);

	decoded_t decoded;
	operand_t op_j;
	operand_t op_k;
	operand_t op_src;
	logic issue_fire;

	// ROB looks up the producers of busy registers
	assign rob_tag_a = reg_a.rob_entry;
	assign rob_tag_b = reg_b.rob_entry;

	issue_decode i_decode
	(
		.clk(clk),
		.arst_n(arst_n),
		.flush(flush),
		.instr_valid(instr_valid),
		.instr(instr),
		.instr_ready(instr_ready),
		.issue_fire(issue_fire),
		.decoded(decoded),
		.sr1_idx(sr1_idx),
		.src2_idx(src2_idx)
	);

	operand_resolve i_resolve_j
	(
		.reg_in(reg_a),
		.rob_in(rob_a),
		.cdb(cdb),
		.operand(op_j)
	);

	operand_resolve i_resolve_k
	(
		.reg_in(reg_b),
		.rob_in(rob_b),
		.cdb(cdb),
		.operand(op_k)
	);

	operand_resolve i_resolve_src	// Store data, also port b
	(
		.reg_in(reg_b),
		.rob_in(rob_b),
		.cdb(cdb),
		.operand(op_src)
	);

	dispatch_router i_router
	(
		.decoded(decoded),
		.op_j(op_j),
		.op_k(op_k),
		.op_src(op_src),
		.alu_busy(alu_busy),
		.ldst_full(ldst_full),
		.rob_full(rob_full),
		.rob_tail(rob_tail),
		.rs_write(rs_write),
		.ldst_write(ldst_write),
		.rob_write(rob_write),
		.reg_busy(reg_busy),
		.issue_fire(issue_fire)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen
(
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	initial
	begin
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		#5 arst_n = 1'b1;	// Released off the edge
	end

endmodule

`default_nettype wire

// ==== tb/tb_issue_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_issue_unit
	import lc3b_isa_pkg::*, tomasulo_pkg::*;
();

	logic clk;
	logic arst_n;
	logic flush;
	logic instr_valid;
	word_t instr;
	logic instr_ready;
	reg_idx_t sr1_idx;
	reg_idx_t src2_idx;
	reg_read_t reg_a;
	reg_read_t reg_b;
	rob_tag_t rob_tag_a;
	rob_tag_t rob_tag_b;
	rob_read_t rob_a;
	rob_read_t rob_b;
	cdb_t cdb;
	logic [2:0] alu_busy;
	logic ldst_full;
	logic rob_full;
	rob_tag_t rob_tail;
	rs_write_t rs_write;
	ldst_write_t ldst_write;
	rob_write_t rob_write;
	reg_busy_t reg_busy;

	// Register file and ROB models
	logic rf_busy [8];
	word_t rf_data [8];
	rob_tag_t rf_tag [8];
	logic rob_valid [8];
	word_t rob_data [8];

	// Reference model state and expected bundles
	logic ref_valid;
	word_t ref_instr;
	logic ref_fire;
	logic ref_ready;
	rs_write_t exp_rs;
	ldst_write_t exp_ldst;
	rob_write_t exp_rob;
	reg_busy_t exp_busy;

	int seed;
	int errors = 0;
	int tests_run = 0;
	int cycles = 0;

	tb_clock_gen i_clock (.clk(clk), .arst_n(arst_n));

	issue_unit i_dut
	(
		.clk(clk), .arst_n(arst_n), .flush(flush),
		.instr_valid(instr_valid), .instr(instr), .instr_ready(instr_ready),
		.sr1_idx(sr1_idx), .src2_idx(src2_idx), .reg_a(reg_a), .reg_b(reg_b),
		.rob_tag_a(rob_tag_a), .rob_tag_b(rob_tag_b), .rob_a(rob_a), .rob_b(rob_b),
		.cdb(cdb), .alu_busy(alu_busy), .ldst_full(ldst_full), .rob_full(rob_full),
		.rob_tail(rob_tail), .rs_write(rs_write), .ldst_write(ldst_write),
		.rob_write(rob_write), .reg_busy(reg_busy)
	);

	always_comb reg_a = '{busy: rf_busy[sr1_idx], data: rf_data[sr1_idx],
		rob_entry: rf_tag[sr1_idx]};
	always_comb reg_b = '{busy: rf_busy[src2_idx], data: rf_data[src2_idx],
		rob_entry: rf_tag[src2_idx]};
	always_comb rob_a = '{valid: rob_valid[rob_tag_a], data: rob_data[rob_tag_a]};
	always_comb rob_b = '{valid: rob_valid[rob_tag_b], data: rob_data[rob_tag_b]};

	// Ready reg first, then CDB, then ROB, else wait on the producer
	function automatic operand_t expect_operand(input reg_idx_t idx);
		operand_t opnd;
		opnd = '{ready: 1'b1, value: rf_data[idx], tag: rf_tag[idx]};
		if (rf_busy[idx])
		begin
			if (cdb.valid && cdb.tag == rf_tag[idx])
				opnd.value = cdb.data;
			else if (rob_valid[rf_tag[idx]])
				opnd.value = rob_data[rf_tag[idx]];
			else
				opnd.ready = 1'b0;
		end
		return opnd;
	endfunction

	always_comb
	begin
		opcode_e op;
		logic alu_op;
		logic mem_op;
		operand_t opnd_b;
		op = opcode_e'(ref_instr[15:12]);
		alu_op = op inside {op_add, op_and, op_not};
		mem_op = op inside {op_ldr, op_str};
		ref_fire = ref_valid && !(rob_full || (alu_op && alu_busy == 3'b111)
			|| (mem_op && ldst_full));
		ref_ready = !ref_valid || ref_fire;
		opnd_b = expect_operand(op == op_str ? ref_instr[11:9] : ref_instr[2:0]);

		exp_rs.write = ref_fire && alu_op;
		exp_rs.station = !alu_busy[0] ? 2'd0 : (!alu_busy[1] ? 2'd1 : 2'd2);
		exp_rs.opcode = op;
		exp_rs.j = expect_operand(ref_instr[8:6]);
		exp_rs.k = opnd_b;
		if (ref_instr[5])
			exp_rs.k = '{ready: 1'b1, value: {{11{ref_instr[4]}}, ref_instr[4:0]}, tag: '0};
		exp_rs.dest = rob_tail;

		exp_ldst.write = ref_fire && mem_op;
		exp_ldst.opcode = op;
		exp_ldst.base = exp_rs.j;
		exp_ldst.src = opnd_b;
		exp_ldst.offset = {{10{ref_instr[5]}}, ref_instr[5:0]} << 1;	// Word offset
		exp_ldst.dest = rob_tail;

		exp_rob = '{write: ref_fire, opcode: op, dest: op == op_str ? 3'd0 : ref_instr[11:9]};
		exp_busy = '{write: ref_fire && op != op_str, dest: ref_instr[11:9], tag: rob_tail};
	end

	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ref_valid <= 1'b0;
			ref_instr <= '0;
		end
		else if (flush)
			ref_valid <= 1'b0;
		else if (ref_ready)
		begin
			ref_valid <= instr_valid;
			if (instr_valid)
				ref_instr <= instr;
		end
	end

	function automatic logic operand_ok(input operand_t got, input operand_t exp);
		if (got.ready != exp.ready)
			return 1'b0;
		return exp.ready ? got.value == exp.value : got.tag == exp.tag;
	endfunction

	function automatic logic rs_ok(input rs_write_t got, input rs_write_t exp);
		if (got.write != exp.write || !exp.write)
			return got.write == exp.write;
		return got.station == exp.station && got.opcode == exp.opcode
			&& operand_ok(got.j, exp.j) && operand_ok(got.k, exp.k) && got.dest == exp.dest;
	endfunction

	function automatic logic ldst_ok(input ldst_write_t got, input ldst_write_t exp);
		if (got.write != exp.write || !exp.write)
			return got.write == exp.write;
		return got.opcode == exp.opcode && operand_ok(got.base, exp.base)
			&& (exp.opcode != op_str || operand_ok(got.src, exp.src))
			&& got.offset == exp.offset && got.dest == exp.dest;
	endfunction

	a_ready: assert property (@(posedge clk) disable iff (!arst_n) instr_ready == ref_ready)
	else
	begin
		$display("CHECK FAILED instr_ready expected %h got %h", $sampled(ref_ready),
			$sampled(instr_ready));
		errors++;
	end

	a_rs: assert property (@(posedge clk) disable iff (!arst_n) rs_ok(rs_write, exp_rs))
	else
	begin
		$display("CHECK FAILED rs_write expected %h got %h", $sampled(exp_rs), $sampled(rs_write));
		errors++;
	end

	a_ldst: assert property (@(posedge clk) disable iff (!arst_n) ldst_ok(ldst_write, exp_ldst))
	else
	begin
		$display("CHECK FAILED ldst_write expected %h got %h", $sampled(exp_ldst),
			$sampled(ldst_write));
		errors++;
	end

	a_rob: assert property (@(posedge clk) disable iff (!arst_n)
		rob_write.write == exp_rob.write && (!exp_rob.write || rob_write == exp_rob))
	else
	begin
		$display("CHECK FAILED rob_write expected %h got %h", $sampled(exp_rob),
			$sampled(rob_write));
		errors++;
	end

	a_busy: assert property (@(posedge clk) disable iff (!arst_n)
		reg_busy.write == exp_busy.write && (!exp_busy.write || reg_busy == exp_busy))
	else
	begin
		$display("CHECK FAILED reg_busy expected %h got %h", $sampled(exp_busy),
			$sampled(reg_busy));
		errors++;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= 2000)
		begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic word_t alu_reg_instr(input opcode_e op, input reg_idx_t dr,
		input reg_idx_t sr1, input reg_idx_t sr2);
		return {op, dr, sr1, 3'b000, sr2};
	endfunction

	function automatic word_t alu_imm_instr(input opcode_e op, input reg_idx_t dr,
		input reg_idx_t sr1, input logic [4:0] imm5);
		return {op, dr, sr1, 1'b1, imm5};
	endfunction

	function automatic word_t mem_instr(input opcode_e op, input reg_idx_t r,
		input reg_idx_t base, input logic [5:0] off6);
		return {op, r, base, off6};
	endfunction

	task automatic next_cycle;
		@(posedge clk);
		#5;
	endtask

	task automatic set_reg(input reg_idx_t idx, input logic busy, input rob_tag_t tag);
		rf_busy[idx] = busy;
		rf_tag[idx] = tag;
		rf_data[idx] = word_t'($random(seed));
	endtask

	// Hold valid until the fetch handshake completes
	task automatic send_instr(input word_t word);
		instr_valid = 1'b1;
		instr = word;
		@(negedge clk);
		while (!instr_ready)
			@(negedge clk);
		next_cycle;
		instr_valid = 1'b0;
	endtask

	task automatic wait_issue;
		@(negedge clk);
		while (!rob_write.write)
			@(negedge clk);
		next_cycle;
	endtask

	task automatic report_test(input int num, input string name, input int errors_before);
		tests_run++;
		$display("test %0d %s: %s", num, name, errors == errors_before ? "ok" : "errors");
	endtask

	initial
	begin
		int errs;
		seed = 50;
		flush = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		cdb = '0;
		alu_busy = 3'b000;
		ldst_full = 1'b0;
		rob_full = 1'b0;
		rob_tail = '0;
		for (int i = 0; i < 8; i++)
		begin
			set_reg(reg_idx_t'(i), 1'b0, '0);
			rob_valid[i] = 1'b0;
			rob_data[i] = word_t'($random(seed));
		end
		@(posedge arst_n);
		next_cycle;

		errs = errors;
		rob_tail = 3'd2;
		send_instr(alu_reg_instr(op_add, 3'd3, 3'd1, 3'd2));
		send_instr(alu_reg_instr(op_and, 3'd4, 3'd5, 3'd6));	// Back to back
		wait_issue;
		rob_tail = 3'd3;
		send_instr(alu_imm_instr(op_not, 3'd7, 3'd0, 5'h1f));
		wait_issue;
		report_test(1, "ready operands", errs);

		errs = errors;
		rob_tail = 3'd4;
		send_instr(alu_imm_instr(op_add, 3'd1, 3'd2, 5'h13));
		send_instr(alu_imm_instr(op_and, 3'd2, 3'd3, 5'h0a));
		send_instr(mem_instr(op_ldr, 3'd3, 3'd4, 6'h3e));
		send_instr(mem_instr(op_str, 3'd5, 3'd6, 6'h15));
		wait_issue;
		report_test(2, "immediates", errs);

		errs = errors;
		set_reg(3'd1, 1'b1, 3'd4);
		set_reg(3'd2, 1'b1, 3'd6);
		rob_valid[4] = 1'b1;	// CDB still has priority
		rob_valid[6] = 1'b1;
		cdb = '{valid: 1'b1, tag: 3'd4, data: 16'hbeef};
		send_instr(alu_reg_instr(op_add, 3'd0, 3'd1, 3'd2));	// CDB for j, ROB for k
		wait_issue;
		rob_valid[4] = 1'b0;
		cdb.tag = 3'd5;
		set_reg(3'd2, 1'b1, 3'd7);
		set_reg(3'd3, 1'b1, 3'd1);
		send_instr(alu_reg_instr(op_and, 3'd0, 3'd2, 3'd1));	// Both wait on tags
		send_instr(mem_instr(op_str, 3'd3, 3'd2, 6'h04));
		wait_issue;
		cdb = '0;
		for (int i = 0; i < 8; i++)
			set_reg(reg_idx_t'(i), 1'b0, '0);
		report_test(3, "operand priority", errs);

		errs = errors;
		alu_busy = 3'b001;
		send_instr(alu_reg_instr(op_add, 3'd1, 3'd2, 3'd3));
		wait_issue;
		alu_busy = 3'b011;
		send_instr(alu_reg_instr(op_add, 3'd2, 3'd3, 3'd4));
		wait_issue;
		alu_busy = 3'b110;
		send_instr(alu_reg_instr(op_add, 3'd3, 3'd4, 3'd5));
		wait_issue;
		alu_busy = 3'b111;
		send_instr(alu_reg_instr(op_and, 3'd4, 3'd5, 3'd6));
		repeat (3) next_cycle;
		alu_busy = 3'b011;
		wait_issue;
		alu_busy = 3'b000;
		rob_full = 1'b1;
		send_instr(alu_imm_instr(op_not, 3'd5, 3'd6, 5'h1f));
		repeat (3) next_cycle;
		rob_full = 1'b0;
		wait_issue;
		report_test(4, "station choice and stalls", errs);

		errs = errors;
		ldst_full = 1'b1;
		send_instr(alu_reg_instr(op_add, 3'd6, 3'd7, 3'd0));
		wait_issue;
		send_instr(mem_instr(op_ldr, 3'd5, 3'd1, 6'h07));
		repeat (3) next_cycle;
		ldst_full = 1'b0;
		wait_issue;
		send_instr(mem_instr(op_str, 3'd6, 3'd1, 6'h21));
		send_instr(mem_instr(op_ldr, 3'd2, 3'd7, 6'h01));
		wait_issue;
		report_test(5, "memory ops", errs);

		errs = errors;
		rob_full = 1'b1;
		send_instr(alu_reg_instr(op_add, 3'd7, 3'd1, 3'd2));
		repeat (2) next_cycle;
		flush = 1'b1;
		next_cycle;
		flush = 1'b0;
		rob_full = 1'b0;
		repeat (3) next_cycle;
		send_instr(alu_reg_instr(op_and, 3'd1, 3'd2, 3'd3));	// Recovers after flush
		wait_issue;
		report_test(6, "flush", errs);

		repeat (2) next_cycle;
		$display("tests run %0d, failed checks %0d", tests_run, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== issue_unit.f ====
logic/lc3b_isa_pkg.sv
logic/tomasulo_pkg.sv
logic/issue_decode.sv
logic/operand_resolve.sv
logic/dispatch_router.sv
logic/issue_unit.sv
tb/tb_clock_gen.sv
tb/tb_issue_unit.sv
